/* rtl/memBusPkg.sv */
`default_nettype none

package memBusPkg;

	// address bus width shared by both requesters and memory
	localparam int AddrWidth = 48;

	// operation codes, low five bits of the 16-bit opm word
	localparam logic [4:0] OpmReady = 5'h00;
	localparam logic [4:0] OpmLoad  = 5'h01;
	localparam logic [4:0] OpmStore = 5'h02;

	// source tag in opm bits 15..12
	localparam logic [3:0] SrcPort1 = 4'h1;
	localparam logic [3:0] SrcPort2 = 4'h2;

	// status codes returned by memory
	localparam logic [1:0] OkReady = 2'b00;
	localparam logic [1:0] OkOk    = 2'b01;
	localparam logic [1:0] OkHold  = 2'b10;
	localparam logic [1:0] OkFault = 2'b11;

	// fault word target values
	localparam logic [3:0] TgtDefault = 4'h0;
	localparam logic [3:0] TgtPort1   = 4'h1;
	localparam logic [3:0] TgtPort2   = 4'h2;
	localparam logic [3:0] TgtBoth    = 4'hF;

	// fault codes
	localparam logic [3:0] FaultRange = 4'h1;

	// one 64-bit fault word, seen either as a plain value or as fields
	typedef union packed {
		logic [63:0] raw;
		struct packed {
			logic [47:0] zeroHigh;
			// bit 15
			logic        valid;
			logic [2:0]  zeroMid;
			// bits 11..8
			logic [3:0]  target;
			logic [3:0]  zeroLow;
			// bits 3..0
			logic [3:0]  code;
		} fields;
	} busExc_t;

endpackage

`default_nettype wire

/* rtl/memBusJoin.sv */
`timescale 1ns/100ps
`default_nettype none

module memBusJoin #(
	parameter int DataWidth = 128
) (
	input  wire                              clock_cpu,
	input  wire                              reset,

	input  wire  [DataWidth-1:0]             mem1OutData,
	input  wire  [memBusPkg::AddrWidth-1:0]  mem1Addr,
	input  wire  [15:0]                      mem1Opm,
	output logic [DataWidth-1:0]             mem1InData,
	output logic [1:0]                       mem1OK,
	output logic [63:0]                      mem1BusExc,

	input  wire  [DataWidth-1:0]             mem2OutData,
	input  wire  [memBusPkg::AddrWidth-1:0]  mem2Addr,
	input  wire  [15:0]                      mem2Opm,
	output logic [DataWidth-1:0]             mem2InData,
	output logic [1:0]                       mem2OK,
	output logic [63:0]                      mem2BusExc,

	output logic [DataWidth-1:0]             memOutData,
	output logic [memBusPkg::AddrWidth-1:0]  memAddr,
	output logic [15:0]                      memOpm,
	input  wire  [DataWidth-1:0]             memInData,
	input  wire  [1:0]                       memOK,
	input  wire  [63:0]                      memBusExc
);

	// input stage from memory
	logic [DataWidth-1:0]      memInDataReg;
	logic [1:0]                memOKReg;
	memBusPkg::busExc_t        memBusExcReg;

	// ownership
	logic                      grant1;
	logic                      grant2;
	logic                      nextGrant1;
	logic                      nextGrant2;
	logic                      retire;
	logic                      nextRetire;
	logic                      tieBreak;

	logic                      req1;
	logic                      req2;
	logic                      ownerReq;
	logic [1:0]                ownerOK;

	// values headed for the output registers
	logic [DataWidth-1:0]              fwdOutData;
	logic [memBusPkg::AddrWidth-1:0]   fwdAddr;
	logic [15:0]                       fwdOpm;
	logic [1:0]                        port1OK;
	logic [1:0]                        port2OK;
	logic [63:0]                       port1Exc;
	logic [63:0]                       port2Exc;

	assign req1 = mem1Opm[4:0] != memBusPkg::OpmReady;
	assign req2 = mem2Opm[4:0] != memBusPkg::OpmReady;

	// owner sees memory status while its request is live;
	// once it has let go, a fresh request waits on hold
	assign ownerReq = grant1 ? req1 : req2;
	assign ownerOK  = !ownerReq ? memBusPkg::OkReady :
		(retire ? memBusPkg::OkHold : memOKReg);

	always_comb
	begin
		nextGrant1 = grant1;
		nextGrant2 = grant2;
		nextRetire = retire;

		fwdOutData = '0;
		fwdAddr    = '0;
		fwdOpm     = {11'h000, memBusPkg::OpmReady};
		port1OK    = memBusPkg::OkReady;
		port2OK    = memBusPkg::OkReady;

		// release only after memory itself is back to ready
		if (grant1 || grant2)
		begin
			if (retire)
			begin
				if (memOKReg == memBusPkg::OkReady)
				begin
					nextGrant1 = 1'b0;
					nextGrant2 = 1'b0;
					nextRetire = 1'b0;
				end
			end
			else if (!ownerReq)
			begin
				nextRetire = 1'b1;
			end
		end

		if (grant1)
		begin
			fwdOutData = mem1OutData;
			fwdAddr    = mem1Addr;
			fwdOpm     = mem1Opm;
			port1OK    = ownerOK;
		end
		else if (grant2)
		begin
			fwdOutData = mem2OutData;
			fwdAddr    = mem2Addr;
			fwdOpm     = mem2Opm;
			port2OK    = ownerOK;
		end
		else if (req1 && !(req2 && tieBreak))
		begin
			nextGrant1 = 1'b1;
		end
		else if (req2)
		begin
			nextGrant2 = 1'b1;
		end

		// memory stays idle while the grant drains
		if (retire)
		begin
			fwdOpm = {11'h000, memBusPkg::OpmReady};
		end
	end

	// fault steering by target field
	always_comb
	begin
		port1Exc = '0;
		port2Exc = '0;
		if (memBusExcReg.fields.valid)
		begin
			case (memBusExcReg.fields.target)
				memBusPkg::TgtDefault,
				memBusPkg::TgtPort1:
				begin
					port1Exc = memBusExcReg.raw;
				end
				memBusPkg::TgtPort2:
				begin
					port2Exc = memBusExcReg.raw;
				end
				memBusPkg::TgtBoth:
				begin
					port1Exc = memBusExcReg.raw;
					port2Exc = memBusExcReg.raw;
				end
				default:
				begin
				end
			endcase
		end
	end

	always_ff @(posedge clock_cpu)
	begin
		memInDataReg <= memInData;
		memOutData   <= fwdOutData;
		memAddr      <= fwdAddr;
		// load data is broadcast, OK tells who owns it
		mem1InData   <= memInDataReg;
		mem2InData   <= memInDataReg;
	end

	always_ff @(posedge clock_cpu)
	begin
		if (reset)
		begin
			grant1       <= 1'b0;
			grant2       <= 1'b0;
			retire       <= 1'b0;
			tieBreak     <= 1'b0;
			memOKReg     <= memBusPkg::OkReady;
			memBusExcReg <= '0;
			memOpm       <= {11'h000, memBusPkg::OpmReady};
			mem1OK       <= memBusPkg::OkReady;
			mem2OK       <= memBusPkg::OkReady;
			mem1BusExc   <= '0;
			mem2BusExc   <= '0;
		end
		else
		begin
			grant1           <= nextGrant1;
			grant2           <= nextGrant2;
			retire           <= nextRetire;
			tieBreak         <= !tieBreak;
			memOKReg         <= memOK;
			memBusExcReg.raw <= memBusExc;
			memOpm           <= fwdOpm;
			mem1OK           <= port1OK;
			mem2OK           <= port2OK;
			mem1BusExc       <= port1Exc;
			mem2BusExc       <= port2Exc;
		end
	end

endmodule

`default_nettype wire

/* rtl/memTileRam.sv */
`timescale 1ns/100ps
`default_nettype none

module memTileRam #(
	parameter int DataWidth   = 128,
	parameter int RamWords    = 256,
	parameter int ReadLatency = 3
) (
	input  wire                              clock_cpu,
	input  wire                              reset,
	input  wire  [DataWidth-1:0]             memOutData,
	input  wire  [memBusPkg::AddrWidth-1:0]  memAddr,
	input  wire  [15:0]                      memOpm,
	output logic [DataWidth-1:0]             memInData,
	output logic [1:0]                       memOK,
	output logic [63:0]                      memBusExc
);

	localparam int IndexWidth = $clog2(RamWords);
	localparam int CountWidth = $clog2(ReadLatency + 1);

	localparam logic [memBusPkg::AddrWidth-1:0] RamLimit =
		memBusPkg::AddrWidth'(RamWords);

	// FSM states
	localparam logic [1:0] StIdle = 2'd0;
	localparam logic [1:0] StBusy = 2'd1;
	localparam logic [1:0] StDone = 2'd2;

	logic [DataWidth-1:0]   ram [RamWords];

	logic [1:0]             state;
	logic [CountWidth-1:0]  count;

	logic                   request;
	logic                   inRange;
	logic                   access;
	logic                   isLoad;
	logic                   isStore;
	logic [IndexWidth-1:0]  index;
	memBusPkg::busExc_t     faultWord;

	assign request = memOpm[4:0] != memBusPkg::OpmReady;
	assign inRange = memAddr < RamLimit;
	assign index   = memAddr[IndexWidth-1:0];
	assign isLoad  = memOpm[4:0] == memBusPkg::OpmLoad;
	assign isStore = memOpm[4:0] == memBusPkg::OpmStore;

	// last cycle of the hold period
	assign access  = (state == StBusy) && (count == '0);

	// range fault goes back to whoever tagged the request
	always_comb
	begin
		faultWord              = '0;
		faultWord.fields.valid  = 1'b1;
		faultWord.fields.target = memOpm[15:12];
		faultWord.fields.code   = memBusPkg::FaultRange;
	end

	always_ff @(posedge clock_cpu)
	begin
		if (access && inRange && isStore)
		begin
			ram[index] <= memOutData;
		end
		if (access && inRange && isLoad)
		begin
			memInData <= ram[index];
		end
	end

	always_ff @(posedge clock_cpu)
	begin
		if (reset)
		begin
			state     <= StIdle;
			count     <= '0;
			memOK     <= memBusPkg::OkReady;
			memBusExc <= '0;
		end
		else
		begin
			case (state)
				StIdle:
				begin
					if (request)
					begin
						memOK <= memBusPkg::OkHold;
						count <= CountWidth'(ReadLatency - 1);
						state <= StBusy;
					end
				end
				StBusy:
				begin
					if (access)
					begin
						state <= StDone;
						if (!inRange)
						begin
							memOK     <= memBusPkg::OkFault;
							memBusExc <= faultWord.raw;
						end
						else
						begin
							memOK <= memBusPkg::OkOk;
						end
					end
					else
					begin
						count <= count - 1'b1;
					end
				end
				StDone:
				begin
					// reply held until the requester lets go
					if (!request)
					begin
						memOK     <= memBusPkg::OkReady;
						memBusExc <= '0;
						state     <= StIdle;
					end
				end
				default:
				begin
					state <= StIdle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/memSubsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module memSubsystem #(
	parameter int DataWidth = 128,
	parameter int RamWords  = 256
) (
	input  wire                              clock_cpu,
	input  wire                              reset,

	input  wire  [DataWidth-1:0]             mem1OutData,
	input  wire  [memBusPkg::AddrWidth-1:0]  mem1Addr,
	input  wire  [15:0]                      mem1Opm,
	output logic [DataWidth-1:0]             mem1InData,
	output logic [1:0]                       mem1OK,
	output logic [63:0]                      mem1BusExc,

	input  wire  [DataWidth-1:0]             mem2OutData,
	input  wire  [memBusPkg::AddrWidth-1:0]  mem2Addr,
	input  wire  [15:0]                      mem2Opm,
	output logic [DataWidth-1:0]             mem2InData,
	output logic [1:0]                       mem2OK,
	output logic [63:0]                      mem2BusExc
);

	// shared memory port between join and RAM
	logic [DataWidth-1:0]             memOutData;
	logic [memBusPkg::AddrWidth-1:0]  memAddr;
	logic [15:0]                      memOpm;
	logic [DataWidth-1:0]             memInData;
	logic [1:0]                       memOK;
	logic [63:0]                      memBusExc;

	memBusJoin #(
		.DataWidth   (DataWidth)
	) busJoin (
		.clock_cpu   (clock_cpu),
		.reset       (reset),
		.mem1OutData (mem1OutData),
		.mem1Addr    (mem1Addr),
		.mem1Opm     (mem1Opm),
		.mem1InData  (mem1InData),
		.mem1OK      (mem1OK),
		.mem1BusExc  (mem1BusExc),
		.mem2OutData (mem2OutData),
		.mem2Addr    (mem2Addr),
		.mem2Opm     (mem2Opm),
		.mem2InData  (mem2InData),
		.mem2OK      (mem2OK),
		.mem2BusExc  (mem2BusExc),
		.memOutData  (memOutData),
		.memAddr     (memAddr),
		.memOpm      (memOpm),
		.memInData   (memInData),
		.memOK       (memOK),
		.memBusExc   (memBusExc)
	);

	memTileRam #(
		.DataWidth   (DataWidth),
		.RamWords    (RamWords)
	) ram (
		.clock_cpu   (clock_cpu),
		.reset       (reset),
		.memOutData  (memOutData),
		.memAddr     (memAddr),
		.memOpm      (memOpm),
		.memInData   (memInData),
		.memOK       (memOK),
		.memBusExc   (memBusExc)
	);

endmodule

`default_nettype wire

/* tb/memJoin_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module memJoin_properties (
	input wire        clock_cpu,
	input wire        reset,
	input wire        grant1,
	input wire        grant2,
	input wire [15:0] memOpm
);

	// one owner of the memory port at a time
	grantsExclusive: assert property (@(posedge clock_cpu) disable iff (reset)
		!(grant1 && grant2))
		else $error("both grant latches set");

	// memory sees idle right after a reset cycle
	idleAfterReset: assert property (@(posedge clock_cpu)
		reset |=> memOpm[4:0] == memBusPkg::OpmReady)
		else $error("memOpm not idle in the cycle after reset");

	// new grants start only from an idle join
	grantFromIdle: assert property (@(posedge clock_cpu) disable iff (reset)
		($rose(grant1) || $rose(grant2)) |-> !$past(grant1 || grant2))
		else $error("grant taken while the other port still owned memory");

endmodule

bind memBusJoin memJoin_properties props (
	.clock_cpu (clock_cpu),
	.reset     (reset),
	.grant1    (grant1),
	.grant2    (grant2),
	.memOpm    (memOpm)
);

`default_nettype wire

/* tb/memSubsystem_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module memSubsystem_tb;

	localparam int DataWidth  = 128;
	localparam int RamWords   = 256;
	localparam int IndexWidth = $clog2(RamWords);
	localparam int Timeout    = 400;
	localparam logic [memBusPkg::AddrWidth-1:0] RamLimit =
		memBusPkg::AddrWidth'(RamWords);

	logic                             clock_cpu;
	logic                             reset;
	logic [DataWidth-1:0]             mem1OutData;
	logic [memBusPkg::AddrWidth-1:0]  mem1Addr;
	logic [15:0]                      mem1Opm;
	logic [DataWidth-1:0]             mem1InData;
	logic [1:0]                       mem1OK;
	logic [63:0]                      mem1BusExc;
	logic [DataWidth-1:0]             mem2OutData;
	logic [memBusPkg::AddrWidth-1:0]  mem2Addr;
	logic [15:0]                      mem2Opm;
	logic [DataWidth-1:0]             mem2InData;
	logic [1:0]                       mem2OK;
	logic [63:0]                      mem2BusExc;

	// shadow copy of the tile memory
	logic [DataWidth-1:0]  shadow [RamWords];
	bit                    written [RamWords];

	int  seed;
	int  errors;
	int  transactions;
	int  tests;
	bit  timedOut;

	memSubsystem #(
		.DataWidth   (DataWidth),
		.RamWords    (RamWords)
	) dut (
		.clock_cpu   (clock_cpu),
		.reset       (reset),
		.mem1OutData (mem1OutData),
		.mem1Addr    (mem1Addr),
		.mem1Opm     (mem1Opm),
		.mem1InData  (mem1InData),
		.mem1OK      (mem1OK),
		.mem1BusExc  (mem1BusExc),
		.mem2OutData (mem2OutData),
		.mem2Addr    (mem2Addr),
		.mem2Opm     (mem2Opm),
		.mem2InData  (mem2InData),
		.mem2OK      (mem2OK),
		.mem2BusExc  (mem2BusExc)
	);

	always #5 clock_cpu = ~clock_cpu;

	function automatic logic [1:0] readOK(input int port);
		return (port == 1) ? mem1OK : mem2OK;
	endfunction

	function automatic logic [63:0] readExc(input int port);
		return (port == 1) ? mem1BusExc : mem2BusExc;
	endfunction

	// valid at bit 15, own port as target, range fault code 1
	function automatic logic [63:0] expectedFault(input int port);
		logic [63:0] word;
		word       = '0;
		word[15]   = 1'b1;
		word[11:8] = 4'(port);
		word[3:0]  = 4'h1;
		return word;
	endfunction

	// small window so loads often hit earlier stores
	function automatic logic [memBusPkg::AddrWidth-1:0] pickAddress(input bit faults);
		int roll;
		roll = {$random(seed)} % 10;
		if (faults && roll == 0)
		begin
			return RamLimit + memBusPkg::AddrWidth'({$random(seed)} % 4096);
		end
		return memBusPkg::AddrWidth'({$random(seed)} % 32);
	endfunction

	function automatic logic [DataWidth-1:0] randomData();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	task automatic driveRequest(input int port, input logic [4:0] op,
		input logic [memBusPkg::AddrWidth-1:0] addr, input logic [DataWidth-1:0] data);
		logic [15:0] opm;
		// source tag only rides along with a live request
		opm = (op == memBusPkg::OpmReady) ? 16'h0000 : {4'(port), 7'h00, op};
		if (port == 1)
		begin
			mem1Opm     = opm;
			mem1Addr    = addr;
			mem1OutData = data;
		end
		else
		begin
			mem2Opm     = opm;
			mem2Addr    = addr;
			mem2OutData = data;
		end
	endtask

	task automatic waitFinal(input int port, output logic [1:0] ok, output bit success);
		int cycles;
		cycles  = 0;
		success = 1'b0;
		ok      = memBusPkg::OkReady;
		while (!success && cycles < Timeout)
		begin
			@(negedge clock_cpu);
			cycles++;
			ok      = readOK(port);
			success = (ok == memBusPkg::OkOk) || (ok == memBusPkg::OkFault);
		end
		if (!success)
		begin
			$display("port %0d got no final OK within %0d cycles", port, Timeout);
			timedOut = 1'b1;
		end
	endtask

	task automatic waitIdle(input int port);
		int cycles;
		bit idle;
		cycles = 0;
		idle   = 1'b0;
		while (!idle && cycles < Timeout)
		begin
			@(negedge clock_cpu);
			cycles++;
			idle = readOK(port) == memBusPkg::OkReady;
		end
		if (!idle)
		begin
			$display("port %0d OK did not return to ready within %0d cycles", port, Timeout);
			timedOut = 1'b1;
		end
	endtask

	task automatic runTransaction(input int port, input bit isStore,
		input logic [memBusPkg::AddrWidth-1:0] addr, input logic [DataWidth-1:0] data);
		logic [1:0]            ok;
		logic [63:0]           exc;
		logic [63:0]           otherExc;
		logic [DataWidth-1:0]  loaded;
		logic [IndexWidth-1:0] index;
		bit                    success;
		index = addr[IndexWidth-1:0];
		driveRequest(port, isStore ? memBusPkg::OpmStore : memBusPkg::OpmLoad, addr, data);
		waitFinal(port, ok, success);
		if (success)
		begin
			transactions++;
			exc      = readExc(port);
			otherExc = readExc(3 - port);
			loaded   = (port == 1) ? mem1InData : mem2InData;
			if (addr < RamLimit)
			begin
				assert (ok == memBusPkg::OkOk && exc == 64'h0) else begin
					$display("ERROR %0t: port %0d at %0h ended with OK %0d, fault word %h",
						$time, port, addr, ok, exc);
					errors++;
				end
				if (isStore)
				begin
					shadow[index]  = data;
					written[index] = 1'b1;
				end
				else if (written[index])
				begin
					assert (loaded === shadow[index]) else begin
						$display("ERROR %0t: port %0d load at %0h read %h, expected %h",
							$time, port, addr, loaded, shadow[index]);
						errors++;
					end
				end
			end
			else
			begin
				assert (ok == memBusPkg::OkFault && exc == expectedFault(port)) else begin
					$display("ERROR %0t: port %0d at %0h gave OK %0d, fault word %h, expected %h",
						$time, port, addr, ok, exc, expectedFault(port));
					errors++;
				end
				assert (otherExc == 64'h0) else begin
					$display("ERROR %0t: port %0d saw fault word %h meant for port %0d",
						$time, 3 - port, otherExc, port);
					errors++;
				end
			end
		end
		driveRequest(port, memBusPkg::OpmReady, '0, '0);
		if (success)
		begin
			waitIdle(port);
		end
	endtask

	task automatic runRequester(input int port, input int count, input bit faults);
		int i;
		int gap;
		bit isStore;
		for (i = 0; i < count && !timedOut; i++)
		begin
			// long gaps let the waiting port win the grant
			gap = {$random(seed)} % 8;
			repeat (gap) @(negedge clock_cpu);
			isStore = ($random(seed) % 2) != 0;
			runTransaction(port, isStore, pickAddress(faults), randomData());
		end
	endtask

	task automatic finishTest(input string name, input int errorsBefore, input int transBefore);
		tests++;
		$display("test %s finished: %0d transactions, %0d errors",
			name, transactions - transBefore, errors - errorsBefore);
	endtask

	task automatic checkReset();
		int errorsBefore;
		errorsBefore = errors;
		repeat (2) @(negedge clock_cpu);
		assert (mem1OK == memBusPkg::OkReady && mem2OK == memBusPkg::OkReady) else begin
			$display("ERROR %0t: OK after reset is %0d and %0d", $time, mem1OK, mem2OK);
			errors++;
		end
		assert (mem1BusExc == 64'h0 && mem2BusExc == 64'h0) else begin
			$display("ERROR %0t: fault words not clear after reset", $time);
			errors++;
		end
		finishTest("reset", errorsBefore, transactions);
	endtask

	task automatic grantHold();
		logic [1:0]           ok;
		logic [DataWidth-1:0] data;
		bit                   success;
		int                   errorsBefore;
		int                   transBefore;
		int                   i;
		errorsBefore = errors;
		transBefore  = transactions;
		data         = randomData();
		// port 1 finishes a load and then sits on it
		driveRequest(1, memBusPkg::OpmLoad, memBusPkg::AddrWidth'(5), '0);
		waitFinal(1, ok, success);
		if (success)
		begin
			transactions++;
			assert (ok == memBusPkg::OkOk) else begin
				$display("ERROR %0t: port 1 long load ended with OK %0d", $time, ok);
				errors++;
			end
			driveRequest(2, memBusPkg::OpmStore, memBusPkg::AddrWidth'(6), data);
			for (i = 0; i < 20; i++)
			begin
				@(negedge clock_cpu);
				assert (mem2OK == memBusPkg::OkReady) else begin
					$display("ERROR %0t: port 2 OK was %0d while port 1 held the grant",
						$time, mem2OK);
					errors++;
				end
			end
			driveRequest(1, memBusPkg::OpmReady, '0, '0);
			waitFinal(2, ok, success);
			if (success)
			begin
				transactions++;
				assert (ok == memBusPkg::OkOk) else begin
					$display("ERROR %0t: port 2 store ended with OK %0d", $time, ok);
					errors++;
				end
				shadow[6]  = data;
				written[6] = 1'b1;
			end
			driveRequest(2, memBusPkg::OpmReady, '0, '0);
			if (success)
			begin
				waitIdle(2);
			end
		end
		else
		begin
			driveRequest(1, memBusPkg::OpmReady, '0, '0);
		end
		finishTest("grant hold", errorsBefore, transBefore);
	endtask

	initial
	begin : main
		int errorsBefore;
		int transBefore;
		clock_cpu    = 1'b0;
		reset        = 1'b1;
		seed         = 19760;
		errors       = 0;
		transactions = 0;
		tests        = 0;
		timedOut     = 1'b0;
		driveRequest(1, memBusPkg::OpmReady, '0, '0);
		driveRequest(2, memBusPkg::OpmReady, '0, '0);
		repeat (3) @(negedge clock_cpu);
		reset = 1'b0;

		checkReset();
		if (!timedOut)
		begin
			errorsBefore = errors;
			transBefore  = transactions;
			runRequester(1, 40, 1'b0);
			finishTest("single port", errorsBefore, transBefore);
		end
		if (!timedOut)
		begin
			errorsBefore = errors;
			transBefore  = transactions;
			fork
				runRequester(1, 60, 1'b1);
				runRequester(2, 60, 1'b1);
			join
			finishTest("contention", errorsBefore, transBefore);
		end
		if (!timedOut)
		begin
			errorsBefore = errors;
			transBefore  = transactions;
			runTransaction(1, 1'b0, RamLimit, '0);
			runTransaction(2, 1'b1, RamLimit + memBusPkg::AddrWidth'(100), randomData());
			runTransaction(1, 1'b1, {memBusPkg::AddrWidth{1'b1}}, randomData());
			// a good access straight after a fault
			runTransaction(2, 1'b0, memBusPkg::AddrWidth'(6), '0);
			finishTest("faults", errorsBefore, transBefore);
		end
		if (!timedOut)
		begin
			grantHold();
		end

		$display("summary: %0d tests, %0d transactions, %0d errors, timeout %0d",
			tests, transactions, errors, timedOut);
		if (errors == 0 && !timedOut)
		begin
			$display("TEST OK");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
rtl/memBusPkg.sv
rtl/memBusJoin.sv
rtl/memTileRam.sv
rtl/memSubsystem.sv
tb/memJoin_properties.sv
tb/memSubsystem_tb.sv

/* Makefile */
TOP = memSubsystem_tb
LOG = sim.log

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

obj_dir/V$(TOP): sim.f $(wildcard rtl/*.sv tb/*.sv)
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing --assert -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
